/* design/stream_pkg.sv */
/*
 * Shared definitions for the 64-to-128 bit stream width bridge.
 * Holds the data and side-field widths, the vector typedefs,
 * the narrow and wide beat structs and the upsizer state type.
 */

package stream_pkg;

    // Width of one input beat of data
    localparam int narrow_width = 64;

    // The bridge packs exactly two narrow beats into one wide word
    localparam int wide_width = 2 * narrow_width;

    // Destination and user fields share one width
    localparam int side_width = 16;

    typedef logic [narrow_width-1:0] narrow_data_t;
    typedef logic [wide_width-1:0]   wide_data_t;
    typedef logic [side_width-1:0]   side_t;

    // Bit 0 flags the lower half, bit 1 the upper half
    typedef logic [1:0] half_keep_t;

    // Keep patterns the upsizer produces
    localparam half_keep_t keep_low  = 2'b01;
    localparam half_keep_t keep_full = 2'b11;

    // One beat on the input side, 97 bits
    typedef struct packed {
        narrow_data_t data;
        side_t        dest;
        side_t        user;
        logic         last;
    } narrow_beat_t;

    // One word on the output side, 163 bits
    typedef struct packed {
        wide_data_t data;
        half_keep_t keep;
        side_t      dest;
        side_t      user;
        logic       last;
    } wide_beat_t;

    // Upsizer state, either waiting for a lower half or holding one
    typedef enum logic {
        pack_empty,
        pack_low_held
    } pack_state_t;

endpackage

/* design/stream_skid_buffer.sv */
/*
 * Two-entry skid buffer at the bridge input.
 * The upstream ready is a flop, so no combinational path runs
 * from the downstream ready back to the source.
 */

module stream_skid_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  stream_pkg::narrow_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::narrow_beat_t mid_beat,
    output logic                     mid_valid,
    input  logic                     mid_ready
);

    // Storage, entry 0 is always the head
    stream_pkg::narrow_beat_t entry [2];

    // Number of beats held, 0 to 2
    logic [1:0] count;
    logic [1:0] count_next;

    logic push;
    logic pop;
    logic empty;

    assign empty = (count == 2'd0);

    // While empty the input is forwarded straight on, but only once
    // it is really accepted, so a beat shown during reset is not lost
    assign mid_valid = empty ? (in_valid & in_ready) : 1'b1;
    assign mid_beat  = empty ? in_beat : entry[0];

    assign push = in_valid & in_ready;
    assign pop  = mid_valid & mid_ready;

    // When empty, a pop can only happen together with a push, so the
    // plain sum covers the pass-through case as well
    assign count_next = count + {1'b0, push} - {1'b0, pop};

    // Fill count and the registered upstream ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count    <= 2'd0;
            in_ready <= 1'b0;
        end else begin
            count    <= count_next;
            // Ready stays up while there is room for at least one more beat
            in_ready <= (count_next < 2'd2);
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        // The second entry moves up when the head leaves a full buffer
        if (pop && count == 2'd2) begin
            entry[0] <= entry[1];
        end
        if (push) begin
            if (count == 2'd0) begin
                // Stored only when the beat did not pass straight through
                if (!pop) begin
                    entry[0] <= in_beat;
                end
            end else if (count == 2'd1) begin
                // Head drains this cycle, so the new beat takes its place
                if (pop) begin
                    entry[0] <= in_beat;
                end else begin
                    entry[1] <= in_beat;
                end
            end
        end
    end

endmodule

/* design/stream_upsizer.sv */
/*
 * Upsizer packing pairs of 64-bit beats into 128-bit words.
 * The first beat of a pair fills the lower half. A last beat seen
 * with no lower half held closes the word early with keep 01.
 * The output word and its valid are registered.
 */

module stream_upsizer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  stream_pkg::narrow_beat_t mid_beat,
    input  logic                     mid_valid,
    output logic                     mid_ready,
    output stream_pkg::wide_beat_t   out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    stream_pkg::pack_state_t state;
    stream_pkg::pack_state_t state_next;

    // Data of the lower half while a pair is being built
    stream_pkg::narrow_data_t low_half;

    // Word assembled from the current beat, loaded when it completes
    stream_pkg::wide_beat_t next_word;

    logic accept;
    logic complete;
    logic hold_low;

    // The output register is free or drains in this very cycle
    assign mid_ready = ~out_valid | out_ready;

    assign accept = mid_valid & mid_ready;

    // A beat completes a word when a lower half waits or when it is
    // the end of a packet
    assign complete = accept &
        ((state == stream_pkg::pack_low_held) | mid_beat.last);

    // Otherwise an accepted beat opens a new pair as its lower half
    assign hold_low = accept & ~complete;

    // Next state
    always_comb begin
        state_next = state;
        if (complete) begin
            state_next = stream_pkg::pack_empty;
        end else if (hold_low) begin
            state_next = stream_pkg::pack_low_held;
        end
    end

    // Assembly of the outgoing word
    always_comb begin
        if (state == stream_pkg::pack_low_held) begin
            // Full pair, earlier beat low and current beat high
            next_word.data = {mid_beat.data, low_half};
            next_word.keep = stream_pkg::keep_full;
        end else begin
            // Early close, upper half left at zero
            next_word.data = {stream_pkg::narrow_data_t'('0), mid_beat.data};
            next_word.keep = stream_pkg::keep_low;
        end
        // Side fields always follow the beat that completes the word
        next_word.dest = mid_beat.dest;
        next_word.user = mid_beat.user;
        next_word.last = mid_beat.last;
    end

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= stream_pkg::pack_empty;
            out_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (complete) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (hold_low) begin
            low_half <= mid_beat.data;
        end
        // A complete word only arrives while the output is free or
        // draining, so a pending word is never overwritten
        if (complete) begin
            out_beat <= next_word;
        end
    end

endmodule

/* design/stream_width_bridge.sv */
/*
 * Top level of the 64-to-128 bit stream width bridge.
 * An input skid buffer feeds the upsizer, which drives the
 * registered wide output.
 */

module stream_width_bridge (
    input  logic                     clk,
    input  logic                     rst_n,
    input  stream_pkg::narrow_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::wide_beat_t   out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    // Link between the skid buffer and the upsizer
    stream_pkg::narrow_beat_t mid_beat;
    logic                     mid_valid;
    logic                     mid_ready;

    // Input stage, keeps in_ready off any path from the sink
    stream_skid_buffer i_stream_skid_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .mid_beat  (mid_beat),
        .mid_valid (mid_valid),
        .mid_ready (mid_ready)
    );

    // Packing stage
    // Its ready depends on out_ready, which the skid buffer absorbs
    stream_upsizer i_stream_upsizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .mid_beat  (mid_beat),
        .mid_valid (mid_valid),
        .mid_ready (mid_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* verif/tb_stream_width_bridge.sv */
/*
 * Testbench for the 64-to-128 bit stream width bridge.
 * Drives random packets through the DUT with throttled valid and ready,
 * predicts the packed words with a reference model and checks each one.
 * Also covers reset values, output back-pressure and the steady rate.
 */

module tb_stream_width_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    // Upper bound on the beats sent by all phases together
    localparam int planned_beats  = 40 * 9 + 11 * 9 + 18 * 8;
    localparam int timeout_cycles = planned_beats * 40 + 200;

    // Beats the bridge can hold at once (skid 2, lower half 1, output word 2)
    localparam int max_in_flight = 5;

    // Longest wait for the bridge to empty at the end of a phase
    localparam int drain_limit = 100;

    logic                     clk;
    logic                     rst_n;
    stream_pkg::narrow_beat_t in_beat;
    logic                     in_valid;
    logic                     in_ready;
    stream_pkg::wide_beat_t   out_beat;
    logic                     out_valid;
    logic                     out_ready;

    logic [31:0] lfsr_state = 32'h6a69_8f92;

    // Reference model state and the words it still expects
    stream_pkg::wide_beat_t expected [$];
    logic                   low_held = 1'b0;
    logic [63:0]            low_data;
    int                     in_flight = 0;

    // Stimulus modes
    logic valid_always = 1'b0;
    logic ready_always = 1'b0;
    int   stall_left   = 0;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int word_count  = 0;

    stream_width_bridge i_stream_width_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[62:0], lfsr_bit()};
        end
        return value;
    endfunction

    // High three times out of four
    function automatic logic likely_bit();
        logic [63:0] r;
        r = random_bits(2);
        return r[1:0] != 2'b00;
    endfunction

    function automatic int any_length();
        logic [63:0] r;
        r = random_bits(4);
        return int'(r[3:0]) % 9 + 1;
    endfunction

    function automatic int even_length();
        logic [63:0] r;
        r = random_bits(2);
        return 2 * (int'(r[1:0]) + 1);
    endfunction

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
        check_count++;
        assert (got === want) else begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
        end
    endtask

    // Packing rule: first beat low, completing beat high, early close on last
    task automatic model_accept(input stream_pkg::narrow_beat_t b);
        stream_pkg::wide_beat_t w;
        in_flight++;
        w.dest = b.dest;
        w.user = b.user;
        w.last = b.last;
        if (low_held) begin
            w.data = {b.data, low_data};
            w.keep = 2'b11;
            expected.push_back(w);
            low_held = 1'b0;
        end else if (b.last) begin
            w.data = {64'h0, b.data};
            w.keep = 2'b01;
            expected.push_back(w);
        end else begin
            low_data = b.data;
            low_held = 1'b1;
        end
    endtask

    task automatic check_output();
        stream_pkg::wide_beat_t want;
        check_count++;
        assert (expected.size() != 0) else begin
            error_count++;
            $display("Output word received while the model expected none");
        end
        if (expected.size() != 0) begin
            want = expected.pop_front();
            compare_value("out_beat.data", out_beat.data, want.data);
            compare_value("out_beat.keep", 128'(out_beat.keep), 128'(want.keep));
            compare_value("out_beat.dest", 128'(out_beat.dest), 128'(want.dest));
            compare_value("out_beat.user", 128'(out_beat.user), 128'(want.user));
            compare_value("out_beat.last", 128'(out_beat.last), 128'(want.last));
            // A full word retires two beats, an early-closed one a single beat
            in_flight = in_flight - ((want.keep == 2'b11) ? 2 : 1);
            word_count++;
        end
    endtask

    // Falling edge, out_ready for the coming rising edge is set here
    task automatic tick();
        @(negedge clk);
        cycle_count++;
        if (stall_left > 0) begin
            out_ready = 1'b0;
            stall_left--;
            if (stall_left == 0) begin
                // Every stage should be full by now, so the source is held off
                compare_value("in_ready", 128'(in_ready), 128'(1'b0));
            end
        end else if (ready_always) begin
            out_ready = 1'b1;
        end else begin
            out_ready = likely_bit();
        end
    endtask

    // Registered outputs are stable here, so both handshakes are known ahead
    task automatic observe(output logic accepted);
        accepted = in_valid & in_ready;
        if (accepted) begin
            model_accept(in_beat);
        end
        if (out_valid && out_ready) begin
            check_output();
        end
        check_count++;
        assert (in_flight <= max_in_flight) else begin
            error_count++;
            $display("The bridge accepted more beats than it can hold");
        end
    endtask

    task automatic send_beat(input stream_pkg::narrow_beat_t b);
        logic shown;
        logic done;
        shown = 1'b0;
        done  = 1'b0;
        while (!done) begin
            tick();
            // Once shown, the beat stays on the input until it is taken
            if (!shown) begin
                shown = valid_always | likely_bit();
            end
            in_valid = shown;
            if (shown) begin
                in_beat = b;
            end
            observe(done);
        end
    endtask

    task automatic send_packet(input int len);
        stream_pkg::narrow_beat_t b;
        logic [63:0]              r;
        for (int i = 0; i < len; i++) begin
            b.data = random_bits(64);
            r = random_bits(16);
            b.dest = r[15:0];
            r = random_bits(16);
            b.user = r[15:0];
            b.last = (i == len - 1);
            send_beat(b);
        end
    endtask

    // Idle input until every accepted beat has left as part of a word
    // or the wait limit runs out
    task automatic drain();
        logic unused;
        int   waited;
        waited = 0;
        while (in_flight != 0 && waited < drain_limit) begin
            tick();
            in_valid = 1'b0;
            observe(unused);
            waited++;
        end
    endtask

    initial begin
        int cycles_start;
        int words_start;
        rst_n     = 1'b0;
        in_beat   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        repeat (10) @(negedge clk);
        compare_value("out_valid", 128'(out_valid), 128'(1'b0));
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        compare_value("out_valid", 128'(out_valid), 128'(1'b0));
        compare_value("in_ready", 128'(in_ready), 128'(1'b1));

        // Random packets with random gaps on both sides
        repeat (40) send_packet(any_length());
        drain();

        // Output held off while the source keeps pushing
        valid_always = 1'b1;
        stall_left   = 14;
        send_packet(9);
        repeat (10) send_packet(any_length());
        drain();

        // Full rate, even packets only, so one word every second cycle
        ready_always = 1'b1;
        repeat (2) send_packet(even_length());
        cycles_start = cycle_count;
        words_start  = word_count;
        repeat (16) send_packet(even_length());
        compare_value("out_valid transfers x2 in steady window",
                      128'(2 * (word_count - words_start)),
                      128'(cycle_count - cycles_start));
        drain();

        compare_value("expected queue size", 128'(expected.size()), 128'(0));
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* src.f */
design/stream_pkg.sv
design/stream_skid_buffer.sv
design/stream_upsizer.sv
design/stream_width_bridge.sv
verif/tb_stream_width_bridge.sv

/* Makefile */
# Verilator build and run for the stream width bridge
#
#   make          build and run the testbench, check the log
#   make lint     lint the RTL top level and the testbench
#   make clean    remove build products and the log

VERILATOR ?= verilator
TB_TOP    ?= tb_stream_width_bridge
RTL_TOP   ?= stream_width_bridge
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall

PASS_TEXT := Simulation PASSED
SIM_EXE   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

# The simulator's exit status is not trusted, the log decides
run: build
	./$(SIM_EXE) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Pass message found in $(LOG)"; \
	else \
		echo "Pass message missing from $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
